// ==== sources.f ====
+incdir+sim
source/tag_mem_pkg.sv
source/select_flags.sv
source/cmd_arbiter.sv
source/mem_access_seq.sv
source/tx_serializer.sv
source/tag_mem_top.sv
sim/tb_tag_mem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_tag_mem
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation output holds the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_tag_mem_checks.svh ====
// testbench helpers for the tag memory controller: value check, bounded waits, serial capture
`ifndef TB_TAG_MEM_CHECKS_SVH
`define TB_TAG_MEM_CHECKS_SVH

task automatic tick();
    @(posedge clk);
    #10;
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Fail %s exp %h got %h", name, exp, got);
        $display("FAIL: see errors above");
        $fatal(1);
    end
endtask

function automatic logic probe(input int sig_id);
    case (sig_id)
        SIG_PC_B: return mem_bus.pc_b;
        SIG_WE:   return mem_bus.we;
        SIG_SE:   return mem_bus.se;
        default:  return tx_data_done;
    endcase
endfunction

// polls once per cycle up to limit cycles
task automatic wait_level(input int sig_id, input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (probe(sig_id) !== level && n < limit) begin
        tick();
        n++;
    end
    if (probe(sig_id) !== level) begin
        $display("Error: timeout after %0d cycles waiting for %s", limit, what);
        $display("FAIL: see errors above");
        $fatal(1);
    end
endtask

// one data_clk period per bit, tx_bit read late in the high phase
task automatic capture_word(output logic [WORD_W-1:0] word);
    int b;
    word = '0;
    for (b = 0; b < WORD_W; b++) begin
        data_clk = 1'b1;
        repeat (DCLK_HALF) tick();
        word = {word[WORD_W-2:0], tx_bit};
        data_clk = 1'b0;
        repeat (DCLK_HALF) tick();
    end
endtask

`endif

// ==== sim/tb_tag_mem.sv ====
// testbench for the tag memory controller: clock, memory model and stimulus tables
`timescale 1ns/1ps

module tb_tag_mem;
    import tag_mem_pkg::*;

    typedef struct packed {
        logic [2:0]        code;
        logic [2:0]        sel;
        logic [ADDR_W-1:0] addr;
    } sensor_row_t;

    typedef struct packed {
        logic [2:0] target;
        logic [2:0] action;
        logic       match;  // mask equals word 3
    } select_row_t;

    localparam int SIG_PC_B    = 0;
    localparam int SIG_WE      = 1;
    localparam int SIG_SE      = 2;
    localparam int SIG_DONE    = 3;
    localparam int DCLK_HALF   = 10;  // clk cycles
    localparam int EPC_ROWS    = 6;
    localparam int SENS_ROWS   = 6;
    localparam int SELECT_ROWS = 12;
    localparam int READ_ROWS   = 3;

    logic              clk;
    logic              factory_reset;
    logic              soft_reset;
    logic [CMD_W-1:0]  rx_cmd;
    logic              packetcomplete;
    select_req_t       sel_req;
    logic [1:0]        bank;
    read_range_t       rd_range;
    logic [WORD_W-1:0] epc_data_in;
    logic              epc_data_ready;
    logic [7:0]        adc_data;
    logic [7:0]        sensor_time_stamp;
    logic [2:0]        sensor_code;
    logic              adc_data_ready;
    logic [WORD_W-1:0] mem_read_in;
    logic              data_clk;
    logic              tx_enable;
    mem_bus_t          mem_bus;
    logic              tx_bit;
    logic              tx_data_done;
    logic              sl_flag;
    logic              inven_flag;
    logic [1:0]        session;

    int                done_cycles = 0;
    logic [WORD_W-1:0] mem_model [3][64];
    logic [WORD_W-1:0] epc_words [EPC_ROWS];
    logic [7:0]        sens_ts [SENS_ROWS];
    logic [7:0]        sens_adc [SENS_ROWS];

    sensor_row_t sensor_rows [SENS_ROWS] = '{
        '{3'd1, 3'd2, 6'd0}, '{3'd2, 3'd4, 6'd0}, '{3'd1, 3'd2, 6'd1},
        '{3'd2, 3'd4, 6'd1}, '{3'd1, 3'd2, 6'd2}, '{3'd2, 3'd4, 6'd2}
    };
    select_row_t select_rows [SELECT_ROWS] = '{
        '{3'd0, 3'd0, 1'b1}, '{3'd1, 3'd4, 1'b1}, '{3'd2, 3'd3, 1'b1}, '{3'd3, 3'd0, 1'b0},
        '{3'd4, 3'd5, 1'b1}, '{3'd4, 3'd6, 1'b0}, '{3'd4, 3'd3, 1'b1}, '{3'd0, 3'd7, 1'b0},
        '{3'd1, 3'd2, 1'b1}, '{3'd5, 3'd0, 1'b1}, '{3'd4, 3'd7, 1'b0}, '{3'd2, 3'd4, 1'b0}
    };
    logic [ADDR_W-1:0] read_rows [READ_ROWS] = '{6'd3, 6'd2, 6'd1};  // top address first

    tag_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [1:0] bank_of(input logic [2:0] sel);
        case (sel)
            3'd2:    return 2'd1;
            3'd4:    return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (mem_bus.we) begin
            mem_model[bank_of(mem_bus.sel)][mem_bus.address] <= mem_bus.data;
        end
    end

    assign mem_read_in = mem_bus.se ? mem_model[bank_of(mem_bus.sel)][mem_bus.address] : '0;

    always @(negedge clk) begin
        if (tx_data_done) begin
            done_cycles++;
        end
    end

    // select action codes, matching and non-matching columns
    function automatic logic next_flag(input logic [2:0] action, input logic matched,
                                       input logic cur);
        case ({matched, action})
            4'b1_000, 4'b1_001, 4'b0_100, 4'b0_110: return 1'b1;
            4'b1_100, 4'b1_101, 4'b0_000, 4'b0_010: return 1'b0;
            4'b1_011, 4'b0_111:                     return ~cur;
            default:                                return cur;
        endcase
    endfunction

    `include "tb_tag_mem_checks.svh"

    task automatic observe_write(input logic [2:0] exp_sel, input logic [ADDR_W-1:0] exp_addr,
                                 input logic [WORD_W-1:0] exp_data);
        wait_level(SIG_PC_B, 1'b0, 20, "precharge of a write access");
        check_value("mem_bus.sel", 32'(mem_bus.sel), 32'(exp_sel));
        check_value("mem_bus.address", 32'(mem_bus.address), 32'(exp_addr));
        tick();
        check_value("mem_bus.pc_b", 32'(mem_bus.pc_b), 32'd1);
        check_value("mem_bus.we", 32'(mem_bus.we), 32'd1);
        check_value("mem_bus.data", 32'(mem_bus.data), 32'(exp_data));
        tick();
        check_value("mem_bus.we", 32'(mem_bus.we), 32'd0);  // one cycle only
    endtask

    initial begin
        int i;
        logic [WORD_W-1:0] got_word;
        select_row_t row;
        logic sl_exp;
        logic inven_exp;
        logic [1:0] session_exp;

        void'($urandom(32'h6b8c));
        factory_reset = 1'b1;
        soft_reset = 1'b0;
        rx_cmd = '0;
        packetcomplete = 1'b0;
        sel_req = '0;
        bank = 2'd0;
        rd_range = '0;
        epc_data_in = '0;
        epc_data_ready = 1'b0;
        adc_data = '0;
        sensor_time_stamp = '0;
        sensor_code = '0;
        adc_data_ready = 1'b0;
        data_clk = 1'b0;
        tx_enable = 1'b0;
        for (i = 0; i < EPC_ROWS; i++) begin
            epc_words[i] = 16'($urandom());
        end
        for (i = 0; i < SENS_ROWS; i++) begin
            sens_ts[i] = 8'($urandom());
            sens_adc[i] = 8'($urandom());
        end
        repeat (2) tick();
        factory_reset = 1'b0;
        tick();

        check_value("mem_bus.pc_b", 32'(mem_bus.pc_b), 32'd1);
        check_value("mem_bus.we", 32'(mem_bus.we), 32'd0);
        check_value("mem_bus.se", 32'(mem_bus.se), 32'd0);
        check_value("tx_data_done", 32'(tx_data_done), 32'd0);
        check_value("tx_bit", 32'(tx_bit), 32'd0);
        check_value("sl_flag", 32'(sl_flag), 32'd1);
        check_value("inven_flag", 32'(inven_flag), 32'd1);
        check_value("session", 32'(session), 32'd0);

        rx_cmd[CMD_BIT_WRITE] = 1'b1;
        bank = BANK_EPC;
        repeat (2) tick();
        for (i = 0; i < EPC_ROWS; i++) begin
            epc_data_in = epc_words[i];
            epc_data_ready = 1'b1;
            observe_write(3'd1, ADDR_W'(i), epc_words[i]);
            epc_data_ready = 1'b0;
            repeat (2) tick();
        end

        for (i = 0; i < SENS_ROWS; i++) begin
            sensor_code = sensor_rows[i].code;
            sensor_time_stamp = sens_ts[i];
            adc_data = sens_adc[i];
            adc_data_ready = 1'b1;
            observe_write(sensor_rows[i].sel, sensor_rows[i].addr, {sens_ts[i], sens_adc[i]});
            adc_data_ready = 1'b0;
            repeat (2) tick();
        end

        sl_exp = 1'b1;
        inven_exp = 1'b1;
        session_exp = 2'd0;
        rx_cmd = '0;
        rx_cmd[CMD_BIT_SELECT] = 1'b1;
        for (i = 0; i < SELECT_ROWS; i++) begin
            row = select_rows[i];
            sel_req.target = row.target;
            sel_req.action = row.action;
            sel_req.mask = row.match ? epc_words[3] : ~epc_words[3];
            packetcomplete = 1'b1;
            tick();
            packetcomplete = 1'b0;
            if (row.target < 3'd4) begin
                session_exp = row.target[1:0];
                inven_exp = next_flag(row.action, row.match, inven_exp);
            end else if (row.target == 3'd4) begin
                sl_exp = next_flag(row.action, row.match, sl_exp);
            end
            check_value("sl_flag", 32'(sl_flag), 32'(sl_exp));
            check_value("inven_flag", 32'(inven_flag), 32'(inven_exp));
            check_value("session", 32'(session), 32'(session_exp));
        end

        rx_cmd = '0;
        rx_cmd[CMD_BIT_READ] = 1'b1;
        rd_range.ptr = 8'd1;
        rd_range.words = 8'd3;
        packetcomplete = 1'b1;
        tick();
        packetcomplete = 1'b0;
        repeat (4) tick();  // arm and range load
        tx_enable = 1'b1;
        wait_level(SIG_SE, 1'b1, 20, "first read fetch");
        wait_level(SIG_SE, 1'b0, 20, "end of first read fetch");
        for (i = 0; i < READ_ROWS; i++) begin
            capture_word(got_word);
            check_value("tx_bit word", 32'(got_word), 32'(mem_model[0][read_rows[i]]));
        end
        wait_level(SIG_DONE, 1'b1, 40, "tx_data_done to rise");
        wait_level(SIG_DONE, 1'b0, 2 * TX_DONE_HOLD, "tx_data_done to fall");
        check_value("tx_data_done cycles", 32'(done_cycles), 32'(TX_DONE_HOLD));
        tx_enable = 1'b0;
        tick();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== source/tag_mem_top.sv ====
// RFID tag memory controller top: select flags, arbiter, access sequencer and serializer
`timescale 1ns/1ps

module tag_mem_top (
    input  logic                            clk,
    input  logic                            factory_reset,
    input  logic                            soft_reset,
    input  logic [tag_mem_pkg::CMD_W-1:0]   rx_cmd,
    input  logic                            packetcomplete,
    input  tag_mem_pkg::select_req_t        sel_req,
    input  logic [1:0]                      bank,
    input  tag_mem_pkg::read_range_t        rd_range,
    input  logic [tag_mem_pkg::WORD_W-1:0]  epc_data_in,
    input  logic                            epc_data_ready,
    input  logic [7:0]                      adc_data,
    input  logic [7:0]                      sensor_time_stamp,
    input  logic [2:0]                      sensor_code,
    input  logic                            adc_data_ready,
    input  logic [tag_mem_pkg::WORD_W-1:0]  mem_read_in,
    input  logic                            data_clk,
    input  logic                            tx_enable,
    output tag_mem_pkg::mem_bus_t           mem_bus,
    output logic                            tx_bit,
    output logic                            tx_data_done,
    output logic                            sl_flag,
    output logic                            inven_flag,
    output logic [1:0]                      session
);
    import tag_mem_pkg::*;

    access_kind_t      access_kind;
    logic              access_start;
    logic              select_cmd;
    logic              read_armed;
    logic              busy;
    logic              word_valid;
    logic              words_done;
    logic              next_word;
    logic [WORD_W-1:0] tx_word;

    select_flags u_select_flags (
        .clk(clk), .factory_reset(factory_reset), .soft_reset(soft_reset),
        .packetcomplete(packetcomplete), .select_cmd(select_cmd), .bank(bank),
        .sel_req(sel_req), .mem_bus(mem_bus),
        .sl_flag(sl_flag), .inven_flag(inven_flag), .session(session)
    );

    cmd_arbiter u_cmd_arbiter (
        .clk(clk), .factory_reset(factory_reset), .soft_reset(soft_reset),
        .rx_cmd(rx_cmd), .packetcomplete(packetcomplete), .bank(bank),
        .tx_enable(tx_enable), .epc_data_ready(epc_data_ready),
        .adc_data_ready(adc_data_ready), .sensor_code(sensor_code), .busy(busy),
        .access_kind(access_kind), .access_start(access_start),
        .select_cmd(select_cmd), .read_armed(read_armed)
    );

    mem_access_seq u_mem_access_seq (
        .clk(clk), .factory_reset(factory_reset), .soft_reset(soft_reset),
        .access_kind(access_kind), .access_start(access_start), .rd_range(rd_range),
        .epc_data_in(epc_data_in), .adc_data(adc_data),
        .sensor_time_stamp(sensor_time_stamp), .mem_read_in(mem_read_in),
        .next_word(next_word), .mem_bus(mem_bus), .busy(busy),
        .word_valid(word_valid), .tx_word(tx_word), .words_done(words_done)
    );

    tx_serializer u_tx_serializer (
        .clk(clk), .factory_reset(factory_reset), .soft_reset(soft_reset),
        .data_clk(data_clk), .tx_enable(tx_enable), .read_armed(read_armed),
        .word_valid(word_valid), .tx_word(tx_word), .words_done(words_done),
        .next_word(next_word), .tx_bit(tx_bit), .tx_data_done(tx_data_done)
    );

endmodule

// ==== source/tx_serializer.sv ====
// serial transmitter: shifts fetched words out MSB first on data_clk rises, then holds done
`timescale 1ns/1ps

module tx_serializer (
    input  logic                            clk,
    input  logic                            factory_reset,
    input  logic                            soft_reset,
    input  logic                            data_clk,
    input  logic                            tx_enable,
    input  logic                            read_armed,
    input  logic                            word_valid,
    input  logic [tag_mem_pkg::WORD_W-1:0]  tx_word,
    input  logic                            words_done,
    output logic                            next_word,
    output logic                            tx_bit,
    output logic                            tx_data_done
);
    import tag_mem_pkg::*;

    logic [2:0]            dclk_sr;
    logic                  dclk_rise;
    logic                  tx_en_q;
    logic                  start_req;
    logic                  shifting;
    logic                  have_word;
    logic                  last_bit;
    logic [3:0]            bit_cnt;
    logic [WORD_W-1:0]     shift_reg;
    logic [WORD_W-1:0]     hold_reg;
    logic [WORD_W-1:0]     cur_word;
    logic [HOLD_CNT_W-1:0] hold_cnt;

    assign dclk_rise = dclk_sr[1] & ~dclk_sr[2];
    assign start_req = tx_enable & ~tx_en_q & read_armed;
    assign cur_word  = shifting ? shift_reg : hold_reg;
    assign last_bit  = (bit_cnt == 4'd15);

    always_ff @(posedge clk) begin
        if (word_valid) begin
            hold_reg <= tx_word;
        end
        if (dclk_rise && (shifting || have_word)) begin
            shift_reg <= {cur_word[WORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (factory_reset || soft_reset) begin
            dclk_sr      <= '0;
            tx_en_q      <= 1'b0;
            shifting     <= 1'b0;
            have_word    <= 1'b0;
            bit_cnt      <= '0;
            next_word    <= 1'b0;
            tx_bit       <= 1'b0;
            tx_data_done <= 1'b0;
            hold_cnt     <= '0;
        end else begin
            dclk_sr   <= {dclk_sr[1:0], data_clk};  // two-stage sync plus edge tap
            tx_en_q   <= tx_enable;
            next_word <= start_req;
            if (word_valid) begin
                have_word <= 1'b1;
            end
            if (tx_data_done) begin
                hold_cnt <= hold_cnt + 1'b1;
                if (hold_cnt == HOLD_CNT_W'(TX_DONE_HOLD - 1)) begin
                    tx_data_done <= 1'b0;
                    tx_bit       <= 1'b0;
                end
            end
            if (!tx_enable) begin
                shifting  <= 1'b0;
                have_word <= 1'b0;
                bit_cnt   <= '0;
            end else if (dclk_rise && (shifting || have_word)) begin
                tx_bit   <= cur_word[WORD_W-1];
                bit_cnt  <= bit_cnt + 1'b1;  // wraps to 0 for the next word
                shifting <= ~last_bit;
                if (!shifting) begin
                    have_word <= 1'b0;
                end
                if (last_bit && words_done) begin
                    tx_data_done <= 1'b1;
                    hold_cnt     <= '0;
                end else if (last_bit) begin
                    next_word <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/mem_access_seq.sv ====
// memory access sequencer: precharge/enable/capture/release cycles, write pointers, read fetch
`timescale 1ns/1ps

module mem_access_seq (
    input  logic                            clk,
    input  logic                            factory_reset,
    input  logic                            soft_reset,
    input  tag_mem_pkg::access_kind_t       access_kind,
    input  logic                            access_start,
    input  tag_mem_pkg::read_range_t        rd_range,
    input  logic [tag_mem_pkg::WORD_W-1:0]  epc_data_in,
    input  logic [7:0]                      adc_data,
    input  logic [7:0]                      sensor_time_stamp,
    input  logic [tag_mem_pkg::WORD_W-1:0]  mem_read_in,
    input  logic                            next_word,
    output tag_mem_pkg::mem_bus_t           mem_bus,
    output logic                            busy,
    output logic                            word_valid,
    output logic [tag_mem_pkg::WORD_W-1:0]  tx_word,
    output logic                            words_done
);
    import tag_mem_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_PRE, ST_EN, ST_CAP, ST_REL} seq_state_t;

    seq_state_t        state;
    access_kind_t      cur_kind;
    logic [ADDR_W-1:0] epc_ptr;
    logic [ADDR_W-1:0] s1_ptr;
    logic [ADDR_W-1:0] s2_ptr;
    logic [PTR_W-1:0]  rd_addr;
    logic [PTR_W-1:0]  rd_bottom;
    logic              read_pend;
    logic              wr_go;
    logic              ld_go;
    logic              rd_go;
    logic [2:0]        nxt_sel;
    logic [ADDR_W-1:0] nxt_addr;
    mem_word_u         wr_word;

    assign wr_go = (state == ST_IDLE) && access_start &&
                   (access_kind inside {ACC_EPC_WRITE, ACC_SENSOR1_WRITE, ACC_SENSOR2_WRITE});
    assign ld_go = (state == ST_IDLE) && access_start && (access_kind == ACC_EPC_READ);
    assign rd_go = (state == ST_IDLE) && !access_start && (next_word || read_pend);
    // a fetch about to launch also holds off the arbiter
    assign busy  = (state == ST_PRE) || (state == ST_EN) || (state == ST_CAP) || rd_go;

    always_comb begin
        nxt_sel  = SEL_EPC;
        nxt_addr = rd_addr[ADDR_W-1:0];
        if (wr_go) begin
            case (access_kind)
                ACC_SENSOR1_WRITE: begin
                    nxt_sel  = SEL_SENSOR1;
                    nxt_addr = s1_ptr;
                end
                ACC_SENSOR2_WRITE: begin
                    nxt_sel  = SEL_SENSOR2;
                    nxt_addr = s2_ptr;
                end
                default: nxt_addr = epc_ptr;
            endcase
        end
    end

    always_comb begin
        wr_word.epc = epc_data_in;
        if (cur_kind != ACC_EPC_WRITE) begin
            wr_word.sensor.time_stamp = sensor_time_stamp;
            wr_word.sensor.sample     = adc_data;
        end
    end

    always_ff @(posedge clk) begin
        if (factory_reset || soft_reset) begin
            state        <= ST_IDLE;
            cur_kind     <= ACC_NONE;
            mem_bus.pc_b <= 1'b1;
            mem_bus.we   <= 1'b0;
            mem_bus.se   <= 1'b0;
            read_pend    <= 1'b0;
            word_valid   <= 1'b0;
            words_done   <= 1'b0;
            if (factory_reset) begin
                epc_ptr <= '0;
                s1_ptr  <= '0;
                s2_ptr  <= '0;
            end
        end else begin
            word_valid <= 1'b0;
            read_pend  <= (read_pend || next_word) && !rd_go;
            case (state)
                ST_IDLE: begin
                    if (ld_go) begin
                        rd_addr    <= rd_range.ptr + rd_range.words - 1'b1; // top word first
                        rd_bottom  <= rd_range.ptr;
                        words_done <= 1'b0;
                    end
                    if (wr_go || rd_go) begin
                        cur_kind        <= wr_go ? access_kind : ACC_EPC_READ;
                        mem_bus.pc_b    <= 1'b0;
                        mem_bus.sel     <= nxt_sel;
                        mem_bus.address <= nxt_addr;
                        state           <= ST_PRE;
                    end
                end
                ST_PRE: begin
                    mem_bus.pc_b <= 1'b1;
                    mem_bus.data <= wr_word;
                    mem_bus.se   <= (cur_kind == ACC_EPC_READ);
                    mem_bus.we   <= (cur_kind != ACC_EPC_READ);
                    state        <= ST_EN;
                end
                ST_EN: begin
                    mem_bus.we <= 1'b0;
                    case (cur_kind)
                        ACC_EPC_WRITE:     epc_ptr <= epc_ptr + 1'b1;
                        ACC_SENSOR1_WRITE: s1_ptr  <= s1_ptr + 1'b1;
                        ACC_SENSOR2_WRITE: s2_ptr  <= s2_ptr + 1'b1;
                        default: begin
                            tx_word    <= mem_read_in;
                            word_valid <= 1'b1;
                            words_done <= (rd_addr == rd_bottom);  // bottom reached
                            rd_addr    <= rd_addr - 1'b1;
                        end
                    endcase
                    state <= ST_CAP;
                end
                ST_CAP: begin
                    mem_bus.se <= 1'b0;
                    state      <= ST_REL;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== source/cmd_arbiter.sv ====
// command arbiter: holds the current command and issues one memory access per request
`timescale 1ns/1ps

module cmd_arbiter (
    input  logic                           clk,
    input  logic                           factory_reset,
    input  logic                           soft_reset,
    input  logic [tag_mem_pkg::CMD_W-1:0]  rx_cmd,
    input  logic                           packetcomplete,
    input  logic [1:0]                     bank,
    input  logic                           tx_enable,
    input  logic                           epc_data_ready,
    input  logic                           adc_data_ready,
    input  logic [2:0]                     sensor_code,
    input  logic                           busy,
    output tag_mem_pkg::access_kind_t      access_kind,
    output logic                           access_start,
    output logic                           select_cmd,
    output logic                           read_armed
);
    import tag_mem_pkg::*;

    logic         cmd_write;
    logic         tx_en_q;
    logic         epc_ready_q;
    logic         adc_ready_q;
    logic         tx_fall;
    logic         read_pkt;
    logic         epc_rise;
    logic         adc_rise;
    logic         free;
    logic         sens_pend;
    logic         epc_pend;
    logic         rd_pend;
    logic         sens_req;
    logic         epc_req;
    logic         rd_req;
    access_kind_t sens_kind;
    access_kind_t adc_kind;

    assign select_cmd = rx_cmd[CMD_BIT_SELECT];
    assign tx_fall    = tx_en_q & ~tx_enable;
    assign read_pkt   = packetcomplete & rx_cmd[CMD_BIT_READ] & (bank == BANK_EPC);
    assign epc_rise   = epc_data_ready & ~epc_ready_q & cmd_write & (bank == BANK_EPC);
    assign adc_rise   = adc_data_ready & ~adc_ready_q &
                        (sensor_code == SENSOR1_CODE || sensor_code == SENSOR2_CODE);
    assign adc_kind   = (sensor_code == SENSOR1_CODE) ? ACC_SENSOR1_WRITE : ACC_SENSOR2_WRITE;
    assign sens_req   = sens_pend | adc_rise;
    assign epc_req    = epc_pend | epc_rise;
    assign rd_req     = rd_pend | read_pkt;
    assign free       = ~busy & ~access_start;

    always_ff @(posedge clk) begin
        if (factory_reset || soft_reset) begin
            cmd_write    <= 1'b0;
            read_armed   <= 1'b0;
            tx_en_q      <= 1'b0;
            epc_ready_q  <= 1'b0;
            adc_ready_q  <= 1'b0;
            sens_pend    <= 1'b0;
            epc_pend     <= 1'b0;
            rd_pend      <= 1'b0;
            sens_kind    <= ACC_NONE;
            access_kind  <= ACC_NONE;
            access_start <= 1'b0;
        end else begin
            tx_en_q     <= tx_enable;
            epc_ready_q <= epc_data_ready;
            adc_ready_q <= adc_data_ready;
            // held until tx_enable drops
            if (rx_cmd[CMD_BIT_WRITE]) begin
                cmd_write <= 1'b1;
            end else if (rx_cmd[CMD_BIT_READ] || tx_fall) begin
                cmd_write <= 1'b0;
            end
            if (read_pkt) begin
                read_armed <= 1'b1;
            end else if (tx_fall) begin
                read_armed <= 1'b0;
            end
            if (adc_rise && !sens_pend) begin
                sens_kind <= adc_kind;
            end
            access_start <= 1'b0;
            access_kind  <= ACC_NONE;
            sens_pend    <= sens_req;
            epc_pend     <= epc_req;
            rd_pend      <= rd_req;
            // sensor first, then EPC write, then read range load
            if (free && sens_req) begin
                access_start <= 1'b1;
                access_kind  <= sens_pend ? sens_kind : adc_kind;
                sens_pend    <= 1'b0;
            end else if (free && epc_req) begin
                access_start <= 1'b1;
                access_kind  <= ACC_EPC_WRITE;
                epc_pend     <= 1'b0;
            end else if (free && rd_req) begin
                access_start <= 1'b1;
                access_kind  <= ACC_EPC_READ;
                rd_pend      <= 1'b0;
            end
        end
    end

endmodule

// ==== source/select_flags.sv ====
// select command handler: keeps the code word and updates session, inventoried and SL flags
`timescale 1ns/1ps

module select_flags (
    input  logic                      clk,
    input  logic                      factory_reset,
    input  logic                      soft_reset,
    input  logic                      packetcomplete,
    input  logic                      select_cmd,
    input  logic [1:0]                bank,
    input  tag_mem_pkg::select_req_t  sel_req,
    input  tag_mem_pkg::mem_bus_t     mem_bus,
    output logic                      sl_flag,
    output logic                      inven_flag,
    output logic [1:0]                session
);
    import tag_mem_pkg::*;

    typedef enum logic [1:0] {OP_KEEP, OP_SET, OP_CLR, OP_TOG} flag_op_t;

    logic [WORD_W-1:0] code_word;
    logic              match;
    logic              sel_go;
    flag_op_t          op;

    function automatic logic apply_op(flag_op_t f, logic cur);
        case (f)
            OP_SET:  return 1'b1;
            OP_CLR:  return 1'b0;
            OP_TOG:  return ~cur;
            default: return cur;
        endcase
    endfunction

    assign match  = (sel_req.mask == code_word);
    assign sel_go = packetcomplete && select_cmd && (bank == BANK_EPC);

    // action table, match and mismatch columns
    always_comb begin
        op = OP_KEEP;
        if (match) begin
            case (sel_req.action)
                3'd0, 3'd1: op = OP_SET;
                3'd3:       op = OP_TOG;
                3'd4, 3'd5: op = OP_CLR;
                default:    op = OP_KEEP;
            endcase
        end else begin
            case (sel_req.action)
                3'd0, 3'd2: op = OP_CLR;
                3'd4, 3'd6: op = OP_SET;
                3'd7:       op = OP_TOG;
                default:    op = OP_KEEP;
            endcase
        end
    end

    // snoop the EPC write to word 3
    always_ff @(posedge clk) begin
        if (factory_reset) begin
            code_word <= '0;
        end else if (mem_bus.we && mem_bus.sel == SEL_EPC && mem_bus.address == CODE_WORD_PTR) begin
            code_word <= mem_bus.data.epc;
        end
    end

    always_ff @(posedge clk) begin
        if (factory_reset || soft_reset) begin
            sl_flag    <= 1'b1;
            inven_flag <= 1'b1;
            session    <= 2'd0;
        end else if (sel_go) begin
            if (sel_req.target < 3'd4) begin
                session    <= sel_req.target[1:0];
                inven_flag <= apply_op(op, inven_flag);
            end else if (sel_req.target == 3'd4) begin
                sl_flag <= apply_op(op, sl_flag);  // SL target
            end
        end
    end

endmodule

// ==== source/tag_mem_pkg.sv ====
// tag memory controller package: widths, command bits, select codes and shared types
package tag_mem_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 6;
    localparam int PTR_W  = 8;
    localparam int CMD_W  = 14;

    // one-hot positions in rx_cmd
    localparam int CMD_BIT_SELECT = 4;
    localparam int CMD_BIT_READ   = 7;
    localparam int CMD_BIT_WRITE  = 8;

    localparam logic [1:0] BANK_EPC = 2'd1;

    localparam logic [2:0] SEL_EPC     = 3'd1;
    localparam logic [2:0] SEL_SENSOR1 = 3'd2;
    localparam logic [2:0] SEL_SENSOR2 = 3'd4;

    localparam logic [ADDR_W-1:0] CODE_WORD_PTR = 6'd3; // word compared by select

    localparam logic [2:0] SENSOR1_CODE = 3'd1;
    localparam logic [2:0] SENSOR2_CODE = 3'd2;

    localparam int TX_DONE_HOLD = 100;  // clk cycles
    localparam int HOLD_CNT_W   = $clog2(TX_DONE_HOLD);

    typedef enum logic [2:0] {
        ACC_NONE,
        ACC_EPC_WRITE,
        ACC_SENSOR1_WRITE,
        ACC_SENSOR2_WRITE,
        ACC_EPC_READ
    } access_kind_t;

    typedef struct packed {
        logic [7:0] time_stamp;
        logic [7:0] sample;
    } sensor_sample_t;

    // a stored word is an EPC word or a logged sample
    typedef union packed {
        logic [WORD_W-1:0] epc;
        sensor_sample_t    sensor;
    } mem_word_u;

    typedef struct packed {
        logic              pc_b;
        logic              we;
        logic              se;
        logic [2:0]        sel;
        logic [ADDR_W-1:0] address;
        mem_word_u         data;
    } mem_bus_t;

    typedef struct packed {
        logic [2:0]        target;
        logic [2:0]        action;
        logic [WORD_W-1:0] mask;
    } select_req_t;

    typedef struct packed {
        logic [PTR_W-1:0] ptr;
        logic [PTR_W-1:0] words;
    } read_range_t;

endpackage
